//--- hdl/rasterix_cfg.svh
// Rasterizer configuration
`ifndef RASTERIX_CFG_SVH
`define RASTERIX_CFG_SVH

// Screen resolution in pixels
`define RASTERIX_X_RES 32
`define RASTERIX_Y_RES 32
`define RASTERIX_PIXEL_COUNT (`RASTERIX_X_RES * `RASTERIX_Y_RES)

// Stream and data widths
`define RASTERIX_CMD_WIDTH 32
`define RASTERIX_PIXEL_WIDTH 16
`define RASTERIX_POS_WIDTH 8
`define RASTERIX_WEIGHT_WIDTH 32

// Register file size
`define RASTERIX_REG_COUNT 16

`endif

//--- hdl/rasterixPkg.sv
// Rasterizer types
`default_nettype none

`include "rasterix_cfg.svh"

package rasterixPkg;

    typedef logic [`RASTERIX_POS_WIDTH-1:0] screenPosT;
    typedef logic [$clog2(`RASTERIX_PIXEL_COUNT)-1:0] pixelIndexT;
    typedef logic signed [`RASTERIX_WEIGHT_WIDTH-1:0] weightT;
    // RGB565
    typedef logic [`RASTERIX_PIXEL_WIDTH-1:0] colorT;
    typedef logic [`RASTERIX_CMD_WIDTH-1:0] cmdWordT;

    // Command opcode, bits 31:28
    typedef enum logic [3:0] {
        opWriteReg = 4'h0,
        opDraw     = 4'h1,
        opMemset   = 4'h2,
        opCommit   = 4'h3
    } opcodeT;

    // Register index, bits 3:0 of a write header
    typedef enum logic [3:0] {
        regBbStart, regBbEnd,
        regW0, regW1, regW2,
        regW0IncX, regW1IncX, regW2IncX,
        regW0IncY, regW1IncY, regW2IncY,
        regFragColor, regClearColor,
        regScissorStart, regScissorEnd,
        regFeatureEnable
    } regIndexT;

    typedef struct packed {
        screenPosT y;
        screenPosT x;
    } posT;

    typedef struct packed {
        posT    bbStart;
        posT    bbEnd;
        weightT w0;
        weightT w1;
        weightT w2;
        weightT w0IncX;
        weightT w1IncX;
        weightT w2IncX;
        weightT w0IncY;
        weightT w1IncY;
        weightT w2IncY;
    } triangleT;

    typedef struct packed {
        colorT      fragColor;
        colorT      clearColor;
        posT        scissorStart;
        posT        scissorEnd;
        logic       scissorEnable;
        logic [2:0] colorMask;
    } renderConfT;

    typedef enum logic [1:0] {
        psIdle,
        psRegData,
        psIssue
    } parserStateT;

endpackage

`default_nettype wire

//--- hdl/commandParser.sv
// Command stream parser
`timescale 1ns/1ps
`default_nettype none

`include "rasterix_cfg.svh"

module commandParser import rasterixPkg::*; (
    input  logic       aclk,
    input  logic       arstN,
    input  logic       cmdValid,
    output logic       cmdReady,
    input  cmdWordT    cmdData,
    input  logic       walkerBusy,
    input  logic       fbBusy,
    output triangleT   triangle,
    output renderConfT conf,
    output logic       drawStart,
    output logic       memsetStart,
    output logic       commitStart
);

    parserStateT state;
    opcodeT      pendingOp;
    opcodeT      cmdOp;
    regIndexT    regIdx;
    cmdWordT     regFile [`RASTERIX_REG_COUNT];
    logic        cmdAccept;

    function automatic posT toPos(cmdWordT w);
        posT p;
        p.x = screenPosT'(w[7:0]);
        p.y = screenPosT'(w[23:16]);
        return p;
    endfunction

    ////////////////////
    // Stream handshake
    ////////////////////

    // Stalled while an operation runs so commands stay in order
    assign cmdReady  = (state != psIssue) && !walkerBusy && !fbBusy;
    assign cmdAccept = cmdValid && cmdReady;
    assign cmdOp     = opcodeT'(cmdData[31:28]);

    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            state     <= psIdle;
            pendingOp <= opWriteReg;
            regIdx    <= regBbStart;
            for (int i = 0; i < `RASTERIX_REG_COUNT; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            case (state)
                psIdle: begin
                    if (cmdAccept) begin
                        if (cmdOp == opWriteReg) begin
                            regIdx <= regIndexT'(cmdData[3:0]);
                            state  <= psRegData;
                        end else begin
                            // Unknown opcodes pass through psIssue without a pulse
                            pendingOp <= cmdOp;
                            state     <= psIssue;
                        end
                    end
                end
                psRegData: begin
                    if (cmdAccept) begin
                        regFile[regIdx] <= cmdData;
                        state           <= psIdle;
                    end
                end
                default: begin
                    state <= psIdle;
                end
            endcase
        end
    end

    // One cycle start pulses
    assign drawStart   = (state == psIssue) && (pendingOp == opDraw);
    assign memsetStart = (state == psIssue) && (pendingOp == opMemset);
    assign commitStart = (state == psIssue) && (pendingOp == opCommit);

    ////////////////////
    // Register unpacking
    ////////////////////
    always_comb begin
        triangle.bbStart = toPos(regFile[regBbStart]);
        triangle.bbEnd   = toPos(regFile[regBbEnd]);
        triangle.w0      = weightT'(regFile[regW0]);
        triangle.w1      = weightT'(regFile[regW1]);
        triangle.w2      = weightT'(regFile[regW2]);
        triangle.w0IncX  = weightT'(regFile[regW0IncX]);
        triangle.w1IncX  = weightT'(regFile[regW1IncX]);
        triangle.w2IncX  = weightT'(regFile[regW2IncX]);
        triangle.w0IncY  = weightT'(regFile[regW0IncY]);
        triangle.w1IncY  = weightT'(regFile[regW1IncY]);
        triangle.w2IncY  = weightT'(regFile[regW2IncY]);

        conf.fragColor     = colorT'(regFile[regFragColor][15:0]);
        conf.clearColor    = colorT'(regFile[regClearColor][15:0]);
        conf.scissorStart  = toPos(regFile[regScissorStart]);
        conf.scissorEnd    = toPos(regFile[regScissorEnd]);
        // Bit 0 scissor, bits 3:1 mask for R, G, B
        conf.scissorEnable = regFile[regFeatureEnable][0];
        conf.colorMask     = regFile[regFeatureEnable][3:1];
    end

endmodule

`default_nettype wire

//--- hdl/edgeWalker.sv
// Bounding box edge walker
`timescale 1ns/1ps
`default_nettype none

module edgeWalker import rasterixPkg::*; (
    input  logic     aclk,
    input  logic     arstN,
    input  logic     drawStart,
    input  triangleT triangle,
    output logic     walkerBusy,
    output logic     fragValid,
    input  logic     fragReady,
    output posT      frag
);

    logic   busy;
    posT    pos;
    weightT w [3];
    weightT rowW [3];
    weightT startW [3];
    weightT incX [3];
    weightT incY [3];
    logic   isInside;
    logic   step;
    logic   rowEnd;
    logic   lastPixel;

    assign startW = '{triangle.w0, triangle.w1, triangle.w2};
    assign incX   = '{triangle.w0IncX, triangle.w1IncX, triangle.w2IncX};
    assign incY   = '{triangle.w0IncY, triangle.w1IncY, triangle.w2IncY};

    // Inside when no edge function is negative
    assign isInside  = (w[0] >= 0) && (w[1] >= 0) && (w[2] >= 0);
    // Outside pixels never wait on the handshake
    assign step      = busy && (!isInside || fragReady);
    assign rowEnd    = (pos.x == triangle.bbEnd.x);
    assign lastPixel = rowEnd && (pos.y == triangle.bbEnd.y);

    assign walkerBusy = busy || drawStart;
    assign fragValid  = busy && isInside;
    assign frag       = pos;

    ////////////////////
    // Position counters
    ////////////////////
    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            pos  <= '0;
        end else if (drawStart) begin
            busy <= 1'b1;
            pos  <= triangle.bbStart;
        end else if (step) begin
            if (lastPixel) begin
                busy <= 1'b0;
            end else if (rowEnd) begin
                pos.x <= triangle.bbStart.x;
                pos.y <= pos.y + 1'b1;
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

    ////////////////////
    // Incremental weights
    ////////////////////
    always_ff @(posedge aclk) begin
        for (int i = 0; i < 3; i++) begin
            if (drawStart) begin
                w[i]    <= startW[i];
                rowW[i] <= startW[i];
            end else if (step && !lastPixel) begin
                if (rowEnd) begin
                    // New row restarts from the row start plus one y step
                    w[i]    <= rowW[i] + incY[i];
                    rowW[i] <= rowW[i] + incY[i];
                end else begin
                    w[i] <= w[i] + incX[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/frameBuffer.sv
// Color frame buffer
`timescale 1ns/1ps
`default_nettype none

`include "rasterix_cfg.svh"

module frameBuffer import rasterixPkg::*; (
    input  logic       aclk,
    input  logic       arstN,
    input  logic       fragValid,
    output logic       fragReady,
    input  posT        frag,
    input  renderConfT conf,
    input  logic       memsetStart,
    input  logic       commitStart,
    output logic       fbBusy,
    output logic       fbValid,
    input  logic       fbReady,
    output logic       fbLast,
    output colorT      fbData
);

    localparam pixelIndexT lastIndex = pixelIndexT'(`RASTERIX_PIXEL_COUNT - 1);

    colorT      mem [`RASTERIX_PIXEL_COUNT];
    logic       memsetActive;
    logic       commitActive;
    pixelIndexT sweepIdx;
    posT        sweepPos;
    posT        wrPos;
    logic       scissorPass;
    logic       wrEnable;
    colorT      wrColor;
    colorT      wrMask;
    colorT      chanMask;
    logic       loadBeat;

    function automatic pixelIndexT pixelIndex(posT p);
        return pixelIndexT'(int'(p.y) * `RASTERIX_X_RES + int'(p.x));
    endfunction

    assign fragReady = 1'b1;
    assign fbBusy    = memsetActive || commitActive || memsetStart || commitStart;

    ////////////////////
    // Write port
    ////////////////////
    assign sweepPos.x = screenPosT'(int'(sweepIdx) % `RASTERIX_X_RES);
    assign sweepPos.y = screenPosT'(int'(sweepIdx) / `RASTERIX_X_RES);

    // Memset and fragments share one scissor compare
    assign wrPos       = memsetActive ? sweepPos : frag;
    assign scissorPass = !conf.scissorEnable
        || ((wrPos.x >= conf.scissorStart.x) && (wrPos.x <= conf.scissorEnd.x)
        && (wrPos.y >= conf.scissorStart.y) && (wrPos.y <= conf.scissorEnd.y));

    // RGB565 channel mask
    assign chanMask = {{5{conf.colorMask[2]}}, {6{conf.colorMask[1]}}, {5{conf.colorMask[0]}}};
    assign wrMask   = memsetActive ? '1 : chanMask;
    assign wrColor  = memsetActive ? conf.clearColor : conf.fragColor;
    assign wrEnable = (memsetActive || (fragValid && fragReady)) && scissorPass;

    // Next beat loads when the output register is free or draining
    assign loadBeat = commitActive && !(fbValid && fbLast) && (!fbValid || fbReady);

    ////////////////////
    // Sweep control
    ////////////////////
    always_ff @(posedge aclk or negedge arstN) begin
        if (!arstN) begin
            memsetActive <= 1'b0;
            commitActive <= 1'b0;
            sweepIdx     <= '0;
            fbValid      <= 1'b0;
            fbLast       <= 1'b0;
        end else if (memsetStart) begin
            memsetActive <= 1'b1;
            sweepIdx     <= '0;
        end else if (commitStart) begin
            commitActive <= 1'b1;
            sweepIdx     <= '0;
        end else if (memsetActive) begin
            if (sweepIdx == lastIndex) begin
                memsetActive <= 1'b0;
            end
            sweepIdx <= sweepIdx + 1'b1;
        end else if (commitActive) begin
            if (fbValid && fbReady && fbLast) begin
                commitActive <= 1'b0;
                fbValid      <= 1'b0;
                fbLast       <= 1'b0;
            end else if (loadBeat) begin
                fbValid  <= 1'b1;
                fbLast   <= (sweepIdx == lastIndex);
                sweepIdx <= sweepIdx + 1'b1;
            end
        end
    end

    // Pixel memory and commit data
    always_ff @(posedge aclk) begin
        if (wrEnable) begin
            mem[pixelIndex(wrPos)] <= (mem[pixelIndex(wrPos)] & ~wrMask) | (wrColor & wrMask);
        end
        if (loadBeat) begin
            fbData <= mem[sweepIdx];
        end
    end

endmodule

`default_nettype wire

//--- hdl/rasterix.sv
// Tile rasterizer top
`timescale 1ns/1ps
`default_nettype none

module rasterix import rasterixPkg::*; (
    input  logic    aclk,
    input  logic    arstN,
    input  logic    cmdValid,
    output logic    cmdReady,
    input  cmdWordT cmdData,
    output logic    fbValid,
    input  logic    fbReady,
    output logic    fbLast,
    output colorT   fbData
);

    triangleT   triangle;
    renderConfT conf;
    logic       drawStart;
    logic       memsetStart;
    logic       commitStart;
    logic       walkerBusy;
    logic       fbBusy;
    logic       fragValid;
    logic       fragReady;
    posT        frag;

    commandParser cmdParser (
        .aclk(aclk),
        .arstN(arstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdData(cmdData),
        .walkerBusy(walkerBusy),
        .fbBusy(fbBusy),
        .triangle(triangle),
        .conf(conf),
        .drawStart(drawStart),
        .memsetStart(memsetStart),
        .commitStart(commitStart)
    );

    edgeWalker walker (
        .aclk(aclk),
        .arstN(arstN),
        .drawStart(drawStart),
        .triangle(triangle),
        .walkerBusy(walkerBusy),
        .fragValid(fragValid),
        .fragReady(fragReady),
        .frag(frag)
    );

    frameBuffer colorBuffer (
        .aclk(aclk),
        .arstN(arstN),
        .fragValid(fragValid),
        .fragReady(fragReady),
        .frag(frag),
        .conf(conf),
        .memsetStart(memsetStart),
        .commitStart(commitStart),
        .fbBusy(fbBusy),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

endmodule

`default_nettype wire

//--- testbench/rasterix_chk.sv
// Rasterizer stream checks
`timescale 1ns/1ps
`default_nettype none

module rasterixChk import rasterixPkg::*; (
    input logic  aclk,
    input logic  arstN,
    input logic  walkerBusy,
    input logic  fbBusy,
    input logic  fbValid,
    input logic  fbReady,
    input logic  fbLast,
    input colorT fbData
);

    // Stalled commit beat holds
    holdUnderBackpressure: assert property (@(posedge aclk) disable iff (!arstN)
        fbValid && !fbReady |=> $stable(fbValid) && $stable(fbData) && $stable(fbLast))
        else $error("commit beat changed while fbReady was low");

    // Parser runs one operation at a time
    noOverlap: assert property (@(posedge aclk) disable iff (!arstN)
        !(walkerBusy && fbBusy))
        else $error("walker and frame buffer operations overlapped");

    lastOnlyWhenValid: assert property (@(posedge aclk) disable iff (!arstN)
        fbLast |-> fbValid)
        else $error("fbLast high without fbValid");

endmodule

bind rasterix rasterixChk chk0 (
    .aclk(aclk),
    .arstN(arstN),
    .walkerBusy(walkerBusy),
    .fbBusy(fbBusy),
    .fbValid(fbValid),
    .fbReady(fbReady),
    .fbLast(fbLast),
    .fbData(fbData)
);

`default_nettype wire

//--- testbench/rasterixTb.sv
// Rasterizer testbench
`timescale 1ns/1ps
`default_nettype none

`include "rasterix_cfg.svh"

module rasterixTb import rasterixPkg::*;;

    localparam int pixelCount = `RASTERIX_PIXEL_COUNT;
    localparam int xRes       = `RASTERIX_X_RES;
    // Five commits of about 1030 cycles, one of them at half rate, two memsets,
    // three draws and reset come to roughly 9000 cycles
    localparam int cycleLimit = 40000;

    logic    aclk;
    logic    arstN;
    logic    cmdValid;
    logic    cmdReady;
    cmdWordT cmdData;
    logic    fbValid;
    logic    fbReady;
    logic    fbLast;
    colorT   fbData;

    // Expected image and a copy of the register file
    colorT       model [pixelCount];
    logic [31:0] regs [`RASTERIX_REG_COUNT];
    logic [31:0] lfsr;
    int          cycleCount;
    int          errorCount;
    int          errorsAtStart;
    int          passCount;
    int          failCount;
    string       testName;

    rasterix dut0 (
        .aclk(aclk),
        .arstN(arstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdData(cmdData),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge aclk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the DUT stopped responding", cycleLimit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("Error: %s %s expected %h actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic beginTest(input string name);
        testName      = name;
        errorsAtStart = errorCount;
    endtask

    task automatic endTest();
        if (errorCount == errorsAtStart) begin
            passCount++;
            $display("Test %s passed", testName);
        end else begin
            failCount++;
            $display("Test %s failed with %0d mismatches", testName, errorCount - errorsAtStart);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic scissorPass(input int x, input int y);
        logic [31:0] s;
        logic [31:0] e;
        s = regs[regScissorStart];
        e = regs[regScissorEnd];
        if (!regs[regFeatureEnable][0]) begin
            return 1'b1;
        end
        return x >= int'(s[7:0]) && x <= int'(e[7:0])
            && y >= int'(s[23:16]) && y <= int'(e[23:16]);
    endfunction

    // Edge function evaluated directly at an offset from bbStart
    function automatic int weightAt(input int k, input int dx, input int dy);
        return int'(regs[int'(regW0) + k]) + dx * int'(regs[int'(regW0IncX) + k])
            + dy * int'(regs[int'(regW0IncY) + k]);
    endfunction

    task automatic modelMemset();
        for (int i = 0; i < pixelCount; i++) begin
            if (scissorPass(i % xRes, i / xRes)) begin
                model[i] = colorT'(regs[regClearColor][15:0]);
            end
        end
    endtask

    task automatic modelDraw();
        int    x0;
        int    y0;
        int    idx;
        colorT mask;
        colorT color;
        x0    = int'(regs[regBbStart][7:0]);
        y0    = int'(regs[regBbStart][23:16]);
        mask  = {{5{regs[regFeatureEnable][3]}}, {6{regs[regFeatureEnable][2]}},
                 {5{regs[regFeatureEnable][1]}}};
        color = colorT'(regs[regFragColor][15:0]);
        for (int y = y0; y <= int'(regs[regBbEnd][23:16]); y++) begin
            for (int x = x0; x <= int'(regs[regBbEnd][7:0]); x++) begin
                if (weightAt(0, x - x0, y - y0) >= 0 && weightAt(1, x - x0, y - y0) >= 0
                    && weightAt(2, x - x0, y - y0) >= 0 && scissorPass(x, y)) begin
                    idx        = y * xRes + x;
                    model[idx] = (model[idx] & ~mask) | (color & mask);
                end
            end
        end
    endtask

    ////////////////////
    // Command stream
    ////////////////////
    task automatic sendWord(input cmdWordT w);
        cmdValid = 1'b1;
        cmdData  = w;
        while (!cmdReady) begin
            @(posedge aclk);
            #1;
        end
        @(posedge aclk);
        #1;
        cmdValid = 1'b0;
    endtask

    task automatic waitIdle();
        while (!cmdReady) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic writeReg(input regIndexT idx, input logic [31:0] data);
        sendWord({opWriteReg, 24'h0, idx});
        sendWord(data);
        regs[idx] = data;
    endtask

    task automatic runOp(input opcodeT op);
        sendWord({op, 28'h0});
        waitIdle();
    endtask

    // Collects every beat and compares it with the model in index order
    task automatic commitAndCompare(input logic randomReady);
        int    beat;
        string what;
        beat = 0;
        sendWord({opCommit, 28'h0});
        while (beat < pixelCount) begin
            if (randomReady) begin
                lfsr    = lfsrNext(lfsr);
                fbReady = lfsr[0];
            end else begin
                fbReady = 1'b1;
            end
            if (fbValid && fbReady) begin
                what = $sformatf("pixel %0d", beat);
                checkEq(what, 32'(model[beat]), 32'(fbData));
                checkEq({what, " last"}, 32'(beat == pixelCount - 1), 32'(fbLast));
                beat++;
            end
            @(posedge aclk);
            #1;
        end
        fbReady = 1'b0;
        checkEq("valid after last beat", 32'h0, 32'(fbValid));
        waitIdle();
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic memsetThenCommit();
        beginTest("memset and commit");
        checkEq("cmdReady after reset", 32'h1, 32'(cmdReady));
        checkEq("fbValid after reset", 32'h0, 32'(fbValid));
        writeReg(regClearColor, 32'h0000_1234);
        runOp(opMemset);
        modelMemset();
        commitAndCompare(1'b0);
        endTest();
    endtask

    // Legs on x = 4 and y = 4, hypotenuse x + y = 23
    task automatic drawRightTriangle();
        beginTest("right triangle");
        writeReg(regFeatureEnable, 32'he);
        writeReg(regFragColor, 32'h0000_ab6d);
        writeReg(regBbStart, 32'h0004_0004);
        writeReg(regBbEnd, 32'h0013_0013);
        writeReg(regW0, 32'd0);
        writeReg(regW1, 32'd0);
        writeReg(regW2, 32'd15);
        writeReg(regW0IncX, 32'd1);
        writeReg(regW1IncX, 32'd0);
        writeReg(regW2IncX, 32'hffff_ffff);
        writeReg(regW0IncY, 32'd0);
        writeReg(regW1IncY, 32'd1);
        writeReg(regW2IncY, 32'hffff_ffff);
        runOp(opDraw);
        modelDraw();
        commitAndCompare(1'b0);
        endTest();
    endtask

    task automatic scissoredRedraw();
        beginTest("scissor");
        writeReg(regScissorStart, 32'h0008_0008);
        writeReg(regScissorEnd, 32'h0017_0017);
        writeReg(regFeatureEnable, 32'hf);
        writeReg(regClearColor, 32'h0000_07e0);
        runOp(opMemset);
        modelMemset();
        writeReg(regFragColor, 32'h0000_f800);
        runOp(opDraw);
        modelDraw();
        commitAndCompare(1'b0);
        endTest();
    endtask

    // Shifted triangle over both cleared regions, green channel only
    task automatic greenOnlyMask();
        beginTest("green mask");
        writeReg(regFeatureEnable, 32'h4);
        writeReg(regFragColor, 32'h0000_5555);
        writeReg(regBbStart, 32'h0002_000a);
        writeReg(regBbEnd, 32'h0015_001d);
        writeReg(regW2, 32'd19);
        runOp(opDraw);
        modelDraw();
        commitAndCompare(1'b0);
        endTest();
    endtask

    task automatic randomBackpressure();
        beginTest("commit back-pressure");
        commitAndCompare(1'b1);
        endTest();
    endtask

    initial begin
        arstN      = 1'b0;
        cmdValid   = 1'b0;
        cmdData    = '0;
        fbReady    = 1'b0;
        lfsr       = 32'hca0a;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        for (int i = 0; i < `RASTERIX_REG_COUNT; i++) begin
            regs[i] = '0;
        end
        repeat (16) @(posedge aclk);
        #1;
        arstN = 1'b1;
        @(posedge aclk);
        #1;

        memsetThenCommit();
        drawRightTriangle();
        scissoredRedraw();
        greenOnlyMask();
        randomBackpressure();

        $display("Tests passed %0d, failed %0d, mismatches %0d", passCount, failCount, errorCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/rasterixPkg.sv
hdl/commandParser.sv
hdl/edgeWalker.sv
hdl/frameBuffer.sv
hdl/rasterix.sv
testbench/rasterix_chk.sv
testbench/rasterixTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module rasterixTb -o rasterixSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rasterixSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
